// File: hdl/ifu_params.svh
// IFU parameters for widths, I-cache geometry, fetch buffer depth and reset vector
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// Datapath widths
`define IFU_AW          32
`define IFU_INSN_DW     32
`define IFU_INSN_LEN    4              // Bytes per instruction

// I-cache geometry, 16-byte lines x 8 sets
`define IFU_IC_P_LINE   4
`define IFU_IC_P_SETS   3

// Fetch buffer, depth doubles as initial credit count
`define IFU_FBUF_DEPTH  4
`define IFU_CREDIT_W    3

`define IFU_RESET_PC    32'h8000_0000

`endif

// File: hdl/ifu_pkg.sv
// IFU package with the structs exchanged between fetch stages and the memory port
`include "ifu_params.svh"
`default_nettype none

package ifu_pkg;

   // One fetched instruction, PC gen to fetch buffer
   typedef struct packed {
      logic [`IFU_AW-1:0]      pc;
      logic [`IFU_INSN_DW-1:0] insn;
   } fetch_entry_t;

   // Decode-side view, 65 bits
   typedef struct packed {
      logic [`IFU_AW-1:0]      pc;
      logic [`IFU_INSN_DW-1:0] insn;
      logic                    is_ctrl;    // Branch, jal or jalr
   } dec_entry_t;

   // Burst read request
   typedef struct packed {
      logic [`IFU_AW-1:0] addr;            // Line aligned
      logic [7:0]         len;             // Beats minus one
   } mem_ar_t;

   // One read data beat
   typedef struct packed {
      logic [`IFU_INSN_DW-1:0] data;
      logic                    last;       // Final beat of burst
   } mem_r_t;

endpackage

`default_nettype wire

// File: hdl/ifu_pc_gen.sv
// IFU PC generator that steps the fetch address and pushes hits under fetch credits
`include "ifu_params.svh"
`default_nettype none

module ifu_pc_gen (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    hit_i,        // Lookup result for pc_o
   input  logic [`IFU_INSN_DW-1:0] insn_i,
   input  logic                    credit_i,     // One buffer slot freed
   output logic [`IFU_AW-1:0]      pc_o,
   output logic                    pc_valid_o,
   output logic                    push_o,
   output ifu_pkg::fetch_entry_t   entry_o
);

   logic [`IFU_AW-1:0]       pc_q;
   logic                     pc_valid_q;
   logic [`IFU_CREDIT_W-1:0] credit_cnt_q;     // Free slots in fetch buffer

   // Push only on a hit with a credit in hand
   assign push_o     = pc_valid_q & hit_i & (credit_cnt_q != '0);
   assign entry_o    = '{pc: pc_q, insn: insn_i};
   assign pc_o       = pc_q;
   assign pc_valid_o = pc_valid_q;

   // Fetch address, stalls on miss or no credit
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_q       <= `IFU_RESET_PC;
         pc_valid_q <= 1'b0;
      end else begin
         pc_valid_q <= 1'b1;                   // Valid from first cycle out of reset
         if (push_o) begin
            pc_q <= pc_q + `IFU_AW'(`IFU_INSN_LEN);
         end
      end
   end

   // Credit counter
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         credit_cnt_q <= `IFU_CREDIT_W'(`IFU_FBUF_DEPTH);
      end else begin
         case ({push_o, credit_i})
            2'b10:   credit_cnt_q <= credit_cnt_q - `IFU_CREDIT_W'(1);  // Spend
            2'b01:   credit_cnt_q <= credit_cnt_q + `IFU_CREDIT_W'(1);  // Return
            default: credit_cnt_q <= credit_cnt_q;                    // Both or none
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/ifu_icache.sv
// IFU instruction cache, direct mapped, refilling whole lines over the burst read port
`include "ifu_params.svh"
`default_nettype none

module ifu_icache (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic [`IFU_AW-1:0]      pc_i,
   input  logic                    pc_valid_i,
   output logic                    hit_o,
   output logic [`IFU_INSN_DW-1:0] insn_o,
   // Burst read port
   output logic                    mem_ar_valid_o,
   input  logic                    mem_ar_ready_i,
   output ifu_pkg::mem_ar_t        mem_ar_o,
   input  logic                    mem_r_valid_i,
   input  ifu_pkg::mem_r_t         mem_r_i,
   output logic                    mem_r_ready_o
);

   localparam int unsigned P_INSN = $clog2(`IFU_INSN_LEN);
   localparam int unsigned WORD_W = `IFU_IC_P_LINE - P_INSN;    // Word select bits
   localparam int unsigned WORDS  = 1 << WORD_W;
   localparam int unsigned SETS   = 1 << `IFU_IC_P_SETS;
   localparam int unsigned TAG_W  = `IFU_AW - `IFU_IC_P_LINE - `IFU_IC_P_SETS;

   // Idle, request, refill, commit line
   typedef enum logic [1:0] {
      S_IDLE,
      S_REQ,
      S_REFILL,
      S_FILL
   } state_t;

   state_t                  state_q;
   logic [SETS-1:0]         valid_q;
   logic [TAG_W-1:0]        tag_q [SETS];
   logic [`IFU_INSN_DW-1:0] data_q [SETS][WORDS];
   logic [`IFU_AW-1:0]      fill_addr_q;                   // Line under refill
   logic [WORD_W-1:0]       beat_q;

   logic [`IFU_IC_P_SETS-1:0] idx;
   logic [TAG_W-1:0]          tag;
   logic [WORD_W-1:0]         word;
   logic [`IFU_IC_P_SETS-1:0] fill_idx;
   logic                      miss_start;
   logic                      beat_take;

   // Split the lookup address
   assign idx      = pc_i[`IFU_IC_P_LINE +: `IFU_IC_P_SETS];
   assign tag      = pc_i[`IFU_AW-1 -: TAG_W];
   assign word     = pc_i[P_INSN +: WORD_W];
   assign fill_idx = fill_addr_q[`IFU_IC_P_LINE +: `IFU_IC_P_SETS];

   assign hit_o  = pc_valid_i & valid_q[idx] & (tag_q[idx] == tag);
   assign insn_o = data_q[idx][word];

   // Miss seen only from idle, refill in flight blocks a second request
   assign miss_start = (state_q == S_IDLE) & pc_valid_i & ~hit_o;
   assign beat_take  = (state_q == S_REFILL) & mem_r_valid_i;

   assign mem_ar_valid_o = (state_q == S_REQ);
   assign mem_ar_o       = '{addr: fill_addr_q, len: 8'(WORDS - 1)};
   assign mem_r_ready_o  = (state_q == S_REFILL);

   // FSM, valid bits and beat counter
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= S_IDLE;
         valid_q <= '0;                                    // All lines invalid
         beat_q  <= '0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (miss_start) begin
                  valid_q[idx] <= 1'b0;                    // Victim dropped now
                  state_q      <= S_REQ;
               end
            end
            S_REQ: begin
               beat_q <= '0;
               if (mem_ar_ready_i) state_q <= S_REFILL;   // Request accepted
            end
            S_REFILL: begin
               if (mem_r_valid_i) begin
                  beat_q <= beat_q + WORD_W'(1);
                  if (mem_r_i.last) state_q <= S_FILL;
               end
            end
            default: begin                               // S_FILL
               valid_q[fill_idx] <= 1'b1;
               state_q           <= S_IDLE;
            end
         endcase
      end
   end

   // Tag, line data and request address
   always_ff @(posedge clk) begin
      if (miss_start) begin
         tag_q[idx]  <= tag;
         fill_addr_q <= {pc_i[`IFU_AW-1:`IFU_IC_P_LINE], `IFU_IC_P_LINE'(0)};
      end
      if (beat_take) begin
         data_q[fill_idx][beat_q] <= mem_r_i.data;        // Beats arrive in word order
      end
   end

endmodule

`default_nettype wire

// File: hdl/ifu_fetch_buf.sv
// IFU fetch buffer, circular queue that hands back one credit per popped entry
`include "ifu_params.svh"
`default_nettype none

module ifu_fetch_buf (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  push_i,       // Space guaranteed by credits
   input  ifu_pkg::fetch_entry_t entry_i,
   input  logic                  pop_i,
   output ifu_pkg::fetch_entry_t entry_o,      // Head entry
   output logic                  empty_o,
   output logic                  credit_o
);
   import ifu_pkg::*;

   localparam int unsigned PTR_W = $clog2(`IFU_FBUF_DEPTH);
   localparam int unsigned CNT_W = $clog2(`IFU_FBUF_DEPTH + 1);

   fetch_entry_t     mem_q [`IFU_FBUF_DEPTH];
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W-1:0] wr_ptr_q;
   logic [CNT_W-1:0] count_q;                   // Occupancy
   logic             credit_q;
   logic             do_pop;

   // Wrap at depth, not only at a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(`IFU_FBUF_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
   endfunction

   assign do_pop   = pop_i & (count_q != '0);   // Ignore pop on empty
   assign empty_o  = (count_q == '0);
   assign entry_o  = mem_q[rd_ptr_q];
   assign credit_o = credit_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= '0;
         credit_q <= 1'b0;
      end else begin
         credit_q <= do_pop;                    // Credit one cycle after pop
         if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
         case ({push_i, do_pop})
            2'b10:   count_q <= count_q + CNT_W'(1);
            2'b01:   count_q <= count_q - CNT_W'(1);
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push_i) mem_q[wr_ptr_q] <= entry_i;
   end

endmodule

`default_nettype wire

// File: hdl/ifu_predecode_port.sv
// IFU predecode port, output register that flags control transfers for decode
`include "ifu_params.svh"
`default_nettype none

module ifu_predecode_port (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  ifu_pkg::fetch_entry_t entry_i,     // Buffer head
   input  logic                  empty_i,
   output logic                  pop_o,
   output logic                  dec_valid_o,
   input  logic                  dec_ready_i,
   output ifu_pkg::dec_entry_t   dec_o
);
   import ifu_pkg::*;

   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_JALR   = 7'b1100111;

   dec_entry_t dec_q;                          // Holds until decode takes it
   logic       valid_q;
   logic [6:0] opcode;
   logic       is_ctrl;

   assign opcode  = entry_i.insn[6:0];
   assign is_ctrl = (opcode == OP_BRANCH) | (opcode == OP_JAL) | (opcode == OP_JALR);

   // Refill when register empty or draining this cycle
   assign pop_o       = (~valid_q | dec_ready_i) & ~empty_i;
   assign dec_valid_o = valid_q;
   assign dec_o       = dec_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else if (pop_o) begin
         valid_q <= 1'b1;
      end else if (dec_ready_i) begin
         valid_q <= 1'b0;                      // Taken, nothing behind it
      end
   end

   always_ff @(posedge clk) begin
      if (pop_o) dec_q <= '{pc: entry_i.pc, insn: entry_i.insn, is_ctrl: is_ctrl};
   end

endmodule

`default_nettype wire

// File: hdl/ifu_top.sv
// IFU top, PC gen and I-cache feeding the fetch buffer and the predecode port
`include "ifu_params.svh"
`default_nettype none

module ifu_top (
   input  logic                clk,
   input  logic                rst_n_i,
   // Memory burst read port
   output logic                mem_ar_valid_o,
   input  logic                mem_ar_ready_i,
   output ifu_pkg::mem_ar_t    mem_ar_o,
   input  logic                mem_r_valid_i,
   input  ifu_pkg::mem_r_t     mem_r_i,
   output logic                mem_r_ready_o,
   // Decode port
   output logic                dec_valid_o,
   input  logic                dec_ready_i,
   output ifu_pkg::dec_entry_t dec_o
);
   import ifu_pkg::*;

   logic [`IFU_AW-1:0]      pc;
   logic                    pc_valid;
   logic                    hit;
   logic [`IFU_INSN_DW-1:0] insn;
   logic                    push;
   logic                    pop;
   logic                    credit;                   // Buffer to PC gen
   logic                    buf_empty;
   fetch_entry_t            push_entry;
   fetch_entry_t            head_entry;

   ifu_pc_gen pc_gen_inst (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .hit_i      (hit),
      .insn_i     (insn),
      .credit_i   (credit),
      .pc_o       (pc),
      .pc_valid_o (pc_valid),
      .push_o     (push),
      .entry_o    (push_entry)
   );

   ifu_icache icache_inst (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .pc_i           (pc),
      .pc_valid_i     (pc_valid),
      .hit_o          (hit),
      .insn_o         (insn),
      .mem_ar_valid_o (mem_ar_valid_o),
      .mem_ar_ready_i (mem_ar_ready_i),
      .mem_ar_o       (mem_ar_o),
      .mem_r_valid_i  (mem_r_valid_i),
      .mem_r_i        (mem_r_i),
      .mem_r_ready_o  (mem_r_ready_o)
   );

   ifu_fetch_buf fetch_buf_inst (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .push_i   (push),
      .entry_i  (push_entry),
      .pop_i    (pop),
      .entry_o  (head_entry),
      .empty_o  (buf_empty),
      .credit_o (credit)
   );

   ifu_predecode_port predecode_port_inst (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .entry_i     (head_entry),
      .empty_i     (buf_empty),
      .pop_o       (pop),
      .dec_valid_o (dec_valid_o),
      .dec_ready_i (dec_ready_i),
      .dec_o       (dec_o)
   );

endmodule

`default_nettype wire

// File: dv/ifu_properties.sv
// IFU handshake and credit assertions, bound into the IFU top level
`include "ifu_params.svh"
`default_nettype none

module ifu_properties (
   input logic                clk,
   input logic                rst_n_i,
   input logic                push_i,          // PC gen to fetch buffer
   input logic                credit_i,        // Fetch buffer to PC gen
   input logic                mem_ar_valid_i,
   input logic                mem_ar_ready_i,
   input ifu_pkg::mem_ar_t    mem_ar_i,
   input logic                dec_valid_i,
   input logic                dec_ready_i,
   input ifu_pkg::dec_entry_t dec_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // Shadow of the free slots, one bit wider to catch an overflow
   logic [`IFU_CREDIT_W:0] credits_q;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         credits_q <= (`IFU_CREDIT_W+1)'(`IFU_FBUF_DEPTH);
      end else begin
         case ({push_i, credit_i})
            2'b10:   credits_q <= credits_q - (`IFU_CREDIT_W+1)'(1);
            2'b01:   credits_q <= credits_q + (`IFU_CREDIT_W+1)'(1);
            default: credits_q <= credits_q;
         endcase
      end
   end

   a_push_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
      push_i |-> (credits_q != '0))
      else $error("push issued with no fetch credit left");

   a_credit_max: assert property (@(posedge clk) disable iff (!rst_n_i)
      credits_q <= (`IFU_CREDIT_W+1)'(`IFU_FBUF_DEPTH))
      else $error("credit count above fetch buffer depth");

   // Request held until the memory takes it
   a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      (mem_ar_valid_i && !mem_ar_ready_i) |=> (mem_ar_valid_i && $stable(mem_ar_i)))
      else $error("burst request changed while stalled");

   a_dec_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
      (dec_valid_i && !dec_ready_i) |=> (dec_valid_i && $stable(dec_i)))
      else $error("decode entry changed while stalled");

endmodule

bind ifu_top ifu_properties ifu_properties_inst (
   .clk            (clk),
   .rst_n_i        (rst_n_i),
   .push_i         (push),
   .credit_i       (credit),
   .mem_ar_valid_i (mem_ar_valid_o),
   .mem_ar_ready_i (mem_ar_ready_i),
   .mem_ar_i       (mem_ar_o),
   .dec_valid_i    (dec_valid_o),
   .dec_ready_i    (dec_ready_i),
   .dec_i          (dec_o)
);

`default_nettype wire

// File: dv/ifu_tb.sv
// IFU testbench with burst memory model, random decode stalls and an in-order fetch model
`include "ifu_params.svh"
`default_nettype none

module ifu_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import ifu_pkg::*;

   localparam int NUM_INSNS      = 2000;
   localparam int RESET_CYCLES   = 16;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_INSNS * 40;

   logic       clk;
   logic       rst_n_i;
   logic       mem_ar_valid_o;
   logic       mem_ar_ready_i;
   mem_ar_t    mem_ar_o;
   logic       mem_r_valid_i;
   mem_r_t     mem_r_i;
   logic       mem_r_ready_o;
   logic       dec_valid_o;
   logic       dec_ready_i;
   dec_entry_t dec_o;

   integer seed = 32'h8b56448a;
   int     accepted_count = 0;                 // Instructions taken by decode
   int     req_count = 0;                      // Burst requests seen
   int     error_count = 0;
   logic   run_ended = 1'b0;

   ifu_top ifu_top_inst (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;                  // 4 ns period
   end

   // Word address hash, roughly one word in four is a control transfer
   function automatic logic [31:0] mem_word(input logic [31:0] addr);
      logic [31:0] w;
      logic [31:0] h;
      logic [6:0]  op;
      w = addr >> 2;
      h = (w * 32'h9e37_79b1) ^ (w >> 5) ^ 32'h5bd1_e995;
      if (h[9:8] == 2'b00) begin
         case (h[11:10])
            2'b00:   op = 7'b1100011;          // Branch
            2'b01:   op = 7'b1101111;          // jal
            default: op = 7'b1100111;          // jalr
         endcase
      end else begin
         case (h[11:10])
            2'b00:   op = 7'b0010011;
            2'b01:   op = 7'b0110011;
            2'b10:   op = 7'b0000011;
            default: op = 7'b0100011;
         endcase
      end
      return {h[31:7], op};
   endfunction

   function automatic logic ctrl_expected(input logic [31:0] insn);
      case (insn[6:0])
         7'b1100011, 7'b1101111, 7'b1100111: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   task automatic abort_run(input string reason);
      run_ended = 1'b1;
      $display("%s", reason);
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         error_count++;
         $display("Error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
         abort_run("value mismatch");
      end
   endtask

   // Burst memory, random accept delay and beat gaps
   initial begin : memory_model
      mem_ar_t req;
      int      delay;
      int      gap;
      int      k;
      mem_ar_ready_i = 1'b0;
      mem_r_valid_i  = 1'b0;
      mem_r_i        = '0;
      @(posedge rst_n_i);
      forever begin
         @(negedge clk);
         check_value("mem_r_ready_o", 64'(mem_r_ready_o), 64'(0));   // No burst accepted yet
         if (mem_ar_valid_o) begin
            req = mem_ar_o;
            check_value("mem_ar_o.addr", 64'(req.addr),
                        64'(`IFU_RESET_PC + 32'(req_count << `IFU_IC_P_LINE)));
            check_value("mem_ar_o.len", 64'(req.len), 64'(3));
            req_count++;
            delay = $unsigned($random(seed)) % 4;
            repeat (delay) @(negedge clk);
            mem_ar_ready_i = 1'b1;             // Taken at the next rising edge
            @(negedge clk);
            mem_ar_ready_i = 1'b0;
            for (k = 0; k < 4; k++) begin
               gap = $unsigned($random(seed)) % 3;
               repeat (gap) @(negedge clk);
               mem_r_valid_i = 1'b1;
               mem_r_i = '{data: mem_word(req.addr + 32'(k * 4)), last: (k == 3)};
               while (!mem_r_ready_o) @(negedge clk);
               @(negedge clk);
               mem_r_valid_i = 1'b0;
               mem_r_i       = '0;
            end
         end
      end
   end

   // Decode side, ready high about 60 percent of cycles
   initial begin : decode_model
      dec_entry_t  got;
      logic [31:0] exp_pc;
      dec_ready_i = 1'b0;
      @(posedge rst_n_i);
      forever begin
         @(negedge clk);
         dec_ready_i = ($unsigned($random(seed)) % 100) < 60;
         if (dec_valid_o && dec_ready_i && accepted_count < NUM_INSNS) begin
            got    = dec_o;                    // Stable until the rising edge
            exp_pc = `IFU_RESET_PC + 32'(accepted_count * `IFU_INSN_LEN);
            check_value("dec_o.pc", 64'(got.pc), 64'(exp_pc));
            check_value("dec_o.insn", 64'(got.insn), 64'(mem_word(exp_pc)));
            check_value("dec_o.is_ctrl", 64'(got.is_ctrl),
                        64'(ctrl_expected(mem_word(exp_pc))));
            accepted_count++;
         end
      end
   end

   initial begin : watchdog
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      abort_run("timeout, decode did not receive all instructions in time");
   end

   initial begin : main_seq
      int lo_reqs;
      int hi_reqs;
      rst_n_i = 1'b0;
      repeat (RESET_CYCLES) begin
         @(negedge clk);
         check_value("dec_valid_o", 64'(dec_valid_o), 64'(0));
         check_value("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'(0));
         check_value("mem_r_ready_o", 64'(mem_r_ready_o), 64'(0));
      end
      rst_n_i = 1'b1;                          // Released on a falling edge
      wait (accepted_count == NUM_INSNS);
      // Lines of the accepted range, plus what may sit in the buffer and register
      lo_reqs = (NUM_INSNS * `IFU_INSN_LEN) >> `IFU_IC_P_LINE;
      hi_reqs = (((NUM_INSNS + `IFU_FBUF_DEPTH + 2) * `IFU_INSN_LEN) >> `IFU_IC_P_LINE) + 1;
      if (req_count < lo_reqs || req_count > hi_reqs) begin
         error_count++;
         $display("burst request count %0d outside %0d to %0d", req_count, lo_reqs, hi_reqs);
      end
      if (error_count == 0) begin
         run_ended = 1'b1;
         $display("sim passed");
         $finish;
      end else begin
         abort_run("run ended with errors");
      end
   end

   // Run cut short, e.g. by a failed assertion
   final begin
      if (!run_ended) begin
         $display("run stopped before all checks completed");
         $display("sim failed");
      end
   end

endmodule

`default_nettype wire

// File: ifu.f
+incdir+hdl
hdl/ifu_pkg.sv
hdl/ifu_pc_gen.sv
hdl/ifu_icache.sv
hdl/ifu_fetch_buf.sv
hdl/ifu_predecode_port.sv
hdl/ifu_top.sv
dv/ifu_properties.sv
dv/ifu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the IFU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f ifu.f --top-module ifu_tb -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ_DIR/Vifu_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
   echo "Testbench reported a failure, see $LOG"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi
exit 0
